// File: hdl/dram_pkg.sv
`default_nettype none

package dram_pkg;

    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH = 4;

    localparam int REQ_DEPTH = 16;

    localparam int REFRESH_INTERVAL = 64; // Window end to next demand.
    localparam int REFRESH_CYCLES = 6;

    typedef enum logic [0:0] {
        OP_READ = 1'b0,
        OP_WRITE = 1'b1
    } req_op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_SETUP = 2'd1,
        ST_ACCESS = 2'd2,
        ST_REFRESH = 2'd3
    } sched_state_t;

    // Queue entry and core request, 47 bits.
    typedef struct packed {
        req_op_t op;
        logic [ADDR_WIDTH - 1:0] addr;
        logic [DATA_WIDTH - 1:0] wdata;
        logic [TAG_WIDTH - 1:0] tag;
    } dram_req_t;

    // Read response, 36 bits.
    typedef struct packed {
        logic [DATA_WIDTH - 1:0] rdata;
        logic [TAG_WIDTH - 1:0] tag;
    } dram_rsp_t;

endpackage

`default_nettype wire

// File: hdl/dram_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dram_req_fifo
    import dram_pkg::*;
#(
    parameter int DEPTH = REQ_DEPTH
) (
    input logic clk,
    input logic reset,

    input logic [1:0] enq_en,
    input dram_req_t [1:0] enq_req,

    input logic peek_en,
    output logic [1:0] peek_valid,
    output dram_req_t [1:0] peek,

    input logic [1:0] retire_en,

    output logic full,
    output logic empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dram_req_t mem [DEPTH];
    logic [DEPTH - 1:0] valid;
    logic [PTR_W - 1:0] head;
    logic [PTR_W - 1:0] tail;
    logic [PTR_W - 1:0] head_plus;
    logic [PTR_W - 1:0] tail_plus;
    logic [CNT_W - 1:0] count;

    assign head_plus = head + PTR_W'(1);
    assign tail_plus = tail + PTR_W'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            tail <= tail + PTR_W'(enq_en[0]) + PTR_W'(enq_en[1]);
            head <= head + PTR_W'(retire_en[0]) + PTR_W'(retire_en[1]);
        end
    end

    always_ff @(posedge clk) begin
        if (enq_en[0]) begin
            mem[tail] <= enq_req[0];
        end
        if (enq_en[1]) begin
            mem[tail_plus] <= enq_req[1];
        end
    end

    // Retire clears first so a reused slot ends up valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (retire_en[0]) begin
                valid[head] <= 1'b0;
            end
            if (retire_en[1]) begin
                valid[head_plus] <= 1'b0;
            end
            if (enq_en[0]) begin
                valid[tail] <= 1'b1;
            end
            if (enq_en[1]) begin
                valid[tail_plus] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(enq_en[0]) + CNT_W'(enq_en[1])
                - CNT_W'(retire_en[0]) - CNT_W'(retire_en[1]);
        end
    end

    assign peek_valid[0] = peek_en && valid[head];
    assign peek_valid[1] = peek_en && valid[head_plus];
    assign peek[0] = peek_valid[0] ? mem[head] : '0;
    assign peek[1] = peek_valid[1] ? mem[head_plus] : '0;

    assign full = (count >= CNT_W'(DEPTH - 2)); // Leaves room for one in-flight push.
    assign empty = (count == '0);

    // The core must respect full, so a push never lands on a live entry.
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        !(enq_en[0] && valid[tail]) && !(enq_en[1] && valid[tail_plus]));

    a_retire_valid: assert property (@(posedge clk) disable iff (reset)
        (!retire_en[0] || valid[head])
            && (!retire_en[1] || (retire_en[0] && valid[head_plus])));

endmodule

`default_nettype wire

// File: hdl/write_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module write_combiner
    import dram_pkg::*;
(
    input logic [1:0] peek_valid,
    input dram_req_t [1:0] peek,

    output logic issue_valid,
    output dram_req_t issue_req,
    output logic retire_two
);

    logic both_writes;
    logic same_addr;
    logic combine;

    assign both_writes = (peek[0].op == OP_WRITE) && (peek[1].op == OP_WRITE);
    assign same_addr = (peek[0].addr == peek[1].addr);

    // The older write is fully overwritten by the younger one.
    assign combine = (&peek_valid) && both_writes && same_addr;

    assign issue_valid = peek_valid[0];
    assign retire_two = combine;

    always_comb begin
        if (combine) begin
            issue_req = peek[1];
        end else begin
            issue_req = peek[0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_timer
    import dram_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic refresh_ack,
    output logic refresh_due,
    output logic refresh_active
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W - 1:0] count; // Shared by interval and window phases.
    logic in_window;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(REFRESH_INTERVAL);
            in_window <= 1'b0;
        end else if (in_window) begin
            if (count == '0) begin
                in_window <= 1'b0;
                count <= CNT_W'(REFRESH_INTERVAL);
            end else begin
                count <= count - CNT_W'(1);
            end
        end else if (refresh_due) begin
            if (refresh_ack) begin
                in_window <= 1'b1;
                count <= CNT_W'(REFRESH_CYCLES - 1);
            end
        end else begin
            count <= count - CNT_W'(1);
        end
    end

    assign refresh_due = !in_window && (count == '0); // Held until acknowledged.
    assign refresh_active = in_window;

    a_due_or_active: assert property (@(posedge clk) disable iff (reset)
        !(refresh_due && refresh_active));

    // The scheduler only acknowledges a pending demand.
    a_ack_when_due: assert property (@(posedge clk) disable iff (reset)
        refresh_ack |-> refresh_due ##1 refresh_active);

endmodule

`default_nettype wire

// File: hdl/dram_sched_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dram_sched_fsm
    import dram_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic issue_valid,
    input dram_req_t issue_req,
    input logic retire_two,
    output logic peek_en,
    output logic [1:0] retire_en,

    input logic refresh_due,
    input logic refresh_active,
    output logic refresh_ack,

    output logic psel,
    output logic penable,
    output logic [ADDR_WIDTH - 1:0] paddr,
    output logic pwrite,
    output logic [DATA_WIDTH - 1:0] pwdata,
    input logic [DATA_WIDTH - 1:0] prdata,
    input logic pready,

    output logic rsp_valid,
    output dram_rsp_t rsp
);

    sched_state_t state;
    sched_state_t state_next;

    dram_req_t cur_req; // Request held for the whole transfer.
    logic cur_two;
    logic access_done;

    assign access_done = (state == ST_ACCESS) && pready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (refresh_due) begin
                    state_next = ST_REFRESH;
                end else if (issue_valid) begin
                    state_next = ST_SETUP;
                end
            end
            ST_SETUP: begin
                state_next = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (pready) begin
                    state_next = ST_IDLE;
                end
            end
            ST_REFRESH: begin
                if (!refresh_active) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Latch the combiner's choice as the transfer starts.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && !refresh_due && issue_valid) begin
            cur_req <= issue_req;
            cur_two <= retire_two;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= access_done && (cur_req.op == OP_READ);
        end
    end

    always_ff @(posedge clk) begin
        if (access_done) begin
            rsp.rdata <= prdata;
            rsp.tag <= cur_req.tag;
        end
    end

    assign peek_en = (state == ST_IDLE);
    assign refresh_ack = (state == ST_IDLE) && refresh_due;
    assign retire_en = access_done ? {cur_two, 1'b1} : 2'b00;

    assign psel = (state == ST_SETUP) || (state == ST_ACCESS);
    assign penable = (state == ST_ACCESS);
    assign paddr = cur_req.addr;
    assign pwrite = (cur_req.op == OP_WRITE);
    assign pwdata = cur_req.wdata;

    a_penable_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

    // APB requires the access phase to hold until the slave is ready.
    a_apb_stable: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=>
            psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

`default_nettype wire

// File: hdl/dram_req_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_req_top
    import dram_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic [1:0] req_en,
    input dram_req_t [1:0] req,
    output logic full,

    output logic rsp_valid,
    output dram_rsp_t rsp,

    output logic refresh_active,

    output logic psel,
    output logic penable,
    output logic [ADDR_WIDTH - 1:0] paddr,
    output logic pwrite,
    output logic [DATA_WIDTH - 1:0] pwdata,
    input logic [DATA_WIDTH - 1:0] prdata,
    input logic pready
);

    logic peek_en;
    logic [1:0] peek_valid;
    dram_req_t [1:0] peek;
    logic [1:0] retire_en;

    logic issue_valid;
    dram_req_t issue_req;
    logic retire_two;

    logic refresh_due;
    logic refresh_ack;

    dram_req_fifo #(
        .DEPTH(REQ_DEPTH)
    ) i_fifo (
        .clk(clk),
        .reset(reset),
        .enq_en(req_en),
        .enq_req(req),
        .peek_en(peek_en),
        .peek_valid(peek_valid),
        .peek(peek),
        .retire_en(retire_en),
        .full(full),
        .empty()
    );

    write_combiner i_combiner (
        .peek_valid(peek_valid),
        .peek(peek),
        .issue_valid(issue_valid),
        .issue_req(issue_req),
        .retire_two(retire_two)
    );

    refresh_timer i_refresh (
        .clk(clk),
        .reset(reset),
        .refresh_ack(refresh_ack),
        .refresh_due(refresh_due),
        .refresh_active(refresh_active)
    );

    dram_sched_fsm i_sched (
        .clk(clk),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_req(issue_req),
        .retire_two(retire_two),
        .peek_en(peek_en),
        .retire_en(retire_en),
        .refresh_due(refresh_due),
        .refresh_active(refresh_active),
        .refresh_ack(refresh_ack),
        .psel(psel),
        .penable(penable),
        .paddr(paddr),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .rsp_valid(rsp_valid),
        .rsp(rsp)
    );

endmodule

`default_nettype wire

// File: verif/apb_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mem_slave
    import dram_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic long_wait, // Stretches each access to 8 to 15 wait states.
    input logic psel,
    input logic penable,
    input logic [ADDR_WIDTH - 1:0] paddr,
    input logic pwrite,
    input logic [DATA_WIDTH - 1:0] pwdata,
    output logic [DATA_WIDTH - 1:0] prdata,
    output logic pready
);

    logic [DATA_WIDTH - 1:0] mem [2 ** ADDR_WIDTH]; // Read by hierarchy at the end.
    logic [3:0] wait_cnt;
    integer seed = 32'h227c1215;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2 ** ADDR_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else if (psel && penable && pready && pwrite) begin
            mem[paddr] <= pwdata;
        end
    end

    // Wait states are drawn once per transfer, in its setup cycle.
    always @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (psel && !penable) begin
            if (long_wait) begin
                wait_cnt <= 4'd8 + 4'($random(seed) & 7);
            end else begin
                wait_cnt <= 4'($random(seed) & 3);
            end
        end else if (psel && penable && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 4'd1;
        end
    end

    assign pready = psel && penable && (wait_cnt == '0);
    assign prdata = mem[paddr];

endmodule

`default_nettype wire

// File: verif/dram_req_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dram_req_tb
    import dram_pkg::*;
();

    localparam int WAIT_LIMIT = 4000;
    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

    logic clk;
    logic reset;
    logic [1:0] req_en;
    dram_req_t [1:0] req;
    logic full;
    logic rsp_valid;
    dram_rsp_t rsp;
    logic refresh_active;
    logic psel;
    logic penable;
    logic [ADDR_WIDTH - 1:0] paddr;
    logic pwrite;
    logic [DATA_WIDTH - 1:0] pwdata;
    logic [DATA_WIDTH - 1:0] prdata;
    logic pready;
    logic long_wait;

    integer seed;
    int data_errors;
    int proto_errors;
    int timeouts;
    int core_writes;
    int write_pairs;
    int apb_writes;
    int windows;
    int window_len;
    int wait_cycles;
    int window_start;
    logic saw_full;
    logic [TAG_WIDTH - 1:0] next_tag;
    req_op_t last_op;
    logic [ADDR_WIDTH - 1:0] last_addr;
    logic [DATA_WIDTH - 1:0] model_mem [MEM_WORDS]; // Memory in program order.
    dram_rsp_t exp_q [$];
    dram_rsp_t exp_rsp;

    logic prev_setup;
    logic prev_wait;
    logic [ADDR_WIDTH - 1:0] prev_addr;
    logic prev_write;
    logic [DATA_WIDTH - 1:0] prev_wdata;

    dram_req_top i_dut (
        .clk(clk),
        .reset(reset),
        .req_en(req_en),
        .req(req),
        .full(full),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .refresh_active(refresh_active),
        .psel(psel),
        .penable(penable),
        .paddr(paddr),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    apb_mem_slave i_slave (
        .clk(clk),
        .reset(reset),
        .long_wait(long_wait),
        .psel(psel),
        .penable(penable),
        .paddr(paddr),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic make_request(output dram_req_t r);
        r.op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
        r.addr = ADDR_WIDTH'($random(seed) & 3); // Few addresses make same-address writes common.
        r.wdata = $random(seed);
        r.tag = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic model_push(input dram_req_t r);
        dram_rsp_t e;
        if (r.op == OP_WRITE) begin
            if (last_op == OP_WRITE && last_addr == r.addr) begin
                write_pairs++;
            end
            model_mem[r.addr] = r.wdata;
            core_writes++;
        end else begin
            e.rdata = model_mem[r.addr];
            e.tag = r.tag;
            exp_q.push_back(e);
        end
        last_op = r.op;
        last_addr = r.addr;
    endtask

    task automatic drive_traffic(input int cycles, input int busy);
        dram_req_t r;
        int roll;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            req_en = 2'b00;
            roll = $random(seed) & 7;
            if (!full && roll < busy) begin
                make_request(r);
                req[0] = r;
                req_en[0] = 1'b1;
                model_push(r);
                if (roll[0]) begin
                    make_request(r);
                    req[1] = r;
                    req_en[1] = 1'b1;
                    model_push(r);
                end
            end
        end
        @(negedge clk);
        req_en = 2'b00;
    endtask

    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                proto_errors++;
                $display("Response arrived with no read outstanding");
            end
            if (exp_q.size() != 0) begin
                exp_rsp = exp_q.pop_front();
                assert (rsp.tag == exp_rsp.tag) else begin
                    data_errors++;
                    $display("ERROR rsp.tag: got %h expected %h", rsp.tag, exp_rsp.tag);
                end
                assert (rsp.rdata == exp_rsp.rdata) else begin
                    data_errors++;
                    $display("ERROR rsp.rdata: got %h expected %h", rsp.rdata, exp_rsp.rdata);
                end
            end
        end
    end

    // APB phases and refresh windows.
    always @(negedge clk) begin
        if (!reset) begin
            if (full) begin
                saw_full = 1'b1;
            end
            if (refresh_active) begin
                window_len++;
            end else if (window_len != 0) begin
                assert (window_len == REFRESH_CYCLES) else begin
                    proto_errors++;
                    $display("ERROR refresh_active length: got %h expected %h",
                        window_len, REFRESH_CYCLES);
                end
                windows++;
                window_len = 0;
            end
            assert (!(psel && !penable && refresh_active)) else begin
                proto_errors++;
                $display("A setup cycle began inside a refresh window");
            end
            assert (!(psel && penable) || prev_setup || prev_wait) else begin
                proto_errors++;
                $display("An access cycle came without a setup cycle before it");
            end
            assert (!(prev_setup || prev_wait) || (psel && penable && paddr == prev_addr
                && pwrite == prev_write && pwdata == prev_wdata)) else begin
                proto_errors++;
                $display("APB outputs changed or access dropped before pready");
            end
            if (psel && penable && pready && pwrite) begin
                apb_writes++;
            end
            prev_setup = psel && !penable;
            prev_wait = psel && penable && !pready;
            prev_addr = paddr;
            prev_write = pwrite;
            prev_wdata = pwdata;
        end
    end

    initial begin
        seed = 32'h227c1215;
        reset = 1'b1;
        req_en = 2'b00;
        req = '0;
        long_wait = 1'b0;
        data_errors = 0;
        proto_errors = 0;
        timeouts = 0;
        core_writes = 0;
        write_pairs = 0;
        apb_writes = 0;
        windows = 0;
        window_len = 0;
        saw_full = 1'b0;
        next_tag = '0;
        last_op = OP_READ;
        last_addr = '0;
        prev_setup = 1'b0;
        prev_wait = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (!psel && !penable && !rsp_valid && !full && !refresh_active) else begin
            proto_errors++;
            $display("ERROR reset outputs: got psel %h penable %h rsp_valid %h full %h act %h",
                psel, penable, rsp_valid, full, refresh_active);
        end

        drive_traffic(400, 4);
        long_wait = 1'b1;
        drive_traffic(300, 8);
        long_wait = 1'b0;
        assert (saw_full) else begin
            proto_errors++;
            $display("full never rose while the memory was slow");
        end

        wait_cycles = 0;
        while ((exp_q.size() != 0 || !i_dut.i_fifo.empty || psel)
            && wait_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (wait_cycles < WAIT_LIMIT) else begin
            timeouts++;
            $display("Timed out draining the queue, scheduler in %s",
                i_dut.i_sched.state.name());
        end

        // Refresh must keep running while idle.
        window_start = windows;
        wait_cycles = 0;
        while (windows < window_start + 3 && wait_cycles < 4 * (REFRESH_INTERVAL + 10)) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (windows >= window_start + 3) else begin
            timeouts++;
            $display("Timed out waiting for refresh windows while idle");
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (i_slave.mem[i] == model_mem[i]) else begin
                data_errors++;
                $display("ERROR mem[%h]: got %h expected %h", i, i_slave.mem[i], model_mem[i]);
            end
        end
        assert (apb_writes <= core_writes && apb_writes >= core_writes - write_pairs) else begin
            data_errors++;
            $display("ERROR apb_writes: got %h expected %h to %h",
                apb_writes, core_writes - write_pairs, core_writes);
        end

        $display("Errors: data %0d, protocol %0d, timeout %0d",
            data_errors, proto_errors, timeouts);
        if (data_errors + proto_errors + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dram_req.f
hdl/dram_pkg.sv
hdl/dram_req_fifo.sv
hdl/write_combiner.sv
hdl/refresh_timer.sv
hdl/dram_sched_fsm.sv
hdl/dram_req_top.sv
verif/apb_mem_slave.sv
verif/dram_req_tb.sv

// File: Bender.yml
package:
  name: dram_req

sources:
  - hdl/dram_pkg.sv
  - hdl/dram_req_fifo.sv
  - hdl/write_combiner.sv
  - hdl/refresh_timer.sv
  - hdl/dram_sched_fsm.sv
  - hdl/dram_req_top.sv
  - target: test
    files:
      - verif/apb_mem_slave.sv
      - verif/dram_req_tb.sv
